//--- rtl/mmio_read_responder.sv
// two-stage read pipeline and csr map decode for the 64-bit port
// stage one reduces groups, stage two selects by register index
`timescale 1ns/10ps
`include "mmio_test_config.svh"

module mmio_read_responder
    import mmio_test_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       read_accept,
    input  logic [`MMIO64_ADDR_W-1:0]  address,
    input  logic [7:0]                 byteenable,
    input  logic [`MMIO_USER_W-1:0]    user,
    // 64-bit write record
    input  logic [63:0]                rec64_data,
    input  logic [`MMIO64_ADDR_W-1:0]  rec64_addr,
    input  logic [7:0]                 rec64_mask,
    input  logic [2:0]                 rec64_byte_idx,
    // 512-bit write record
    input  wide_data_u                 rec512_data,
    input  logic [`MMIO512_ADDR_W-1:0] rec512_addr,
    input  logic [63:0]                rec512_mask,
    input  logic [5:0]                 rec512_byte_idx,
    output mmio64_rsp_t                rsp
);

    // feature header: type afu in [63:60], end of list at bit 40
    localparam logic [63:0] FEATURE_HDR = 64'h1000_0100_0000_0000;

    // status: clock MHz in [31:16], bit 4 says wide writes are consumed
    logic [63:0] status_reg;
    assign status_reg = {32'h0, 16'(`MMIO_PCLK_MHZ), 11'h0, 1'b1, 4'h0};

    // byte address of the current request, word address plus offset
    logic [31:0] req_byte_addr;
    assign req_byte_addr = 32'({address, 3'(lowest_byte_idx(64'(byteenable)))});

    // ========================================================================
    // stage one
    // ========================================================================

    logic                    read_q;
    csr_idx_t                idx_q;
    logic [`MMIO_USER_W-1:0] user_q;
    logic [63:0]             hdr_group_q;
    logic [63:0]             wide_word_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            read_q <= 1'b0;
        else
            read_q <= read_accept;
    end

    always_ff @(posedge clk)
    begin
        idx_q  <= csr_idx_t'(address);
        user_q <= user;

        // header, id and byte-address group, low nibble only
        case (address[3:0])
            4'h0:    hdr_group_q <= FEATURE_HDR;
            4'h1:    hdr_group_q <= `MMIO_AFU_ID_L;
            4'h2:    hdr_group_q <= `MMIO_AFU_ID_H;
            // replicated so either 32-bit half reads it
            4'h7:    hdr_group_q <= {req_byte_addr, req_byte_addr};
            default: hdr_group_q <= 64'h0;
        endcase

        // one of the eight wide-data words
        wide_word_q <= rec512_data.words[address[2:0]];
    end

    // ========================================================================
    // stage two
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rsp.readdatavalid <= 1'b0;
        else
            rsp.readdatavalid <= read_q;
    end

    always_ff @(posedge clk)
    begin
        rsp.readresponseuser <= user_q;

        casez (idx_q)
            12'h00?:         rsp.readdata <= hdr_group_q;
            12'h010:         rsp.readdata <= status_reg;
            // narrow write record
            12'h020:         rsp.readdata <= rec64_data;
            12'h030:         rsp.readdata <= 64'({rec64_addr, rec64_byte_idx});
            12'h031:         rsp.readdata <= 64'(rec64_mask);
            // wide write record, 0x40..0x47 only
            12'b0000_0100_0???: rsp.readdata <= wide_word_q;
            12'h050:         rsp.readdata <= 64'({rec512_addr, rec512_byte_idx});
            12'h051:         rsp.readdata <= rec512_mask;
            default:         rsp.readdata <= 64'h0;
        endcase
    end

    // fixed latency, nothing dropped or merged in the pipe
    a_read_latency: assert property (
        @(posedge clk) disable iff (!reset_n)
        read_accept |-> ##2 rsp.readdatavalid
    );

endmodule

//--- rtl/mmio_test_afu.sv
// mmio test target top level
// waitrequest pattern, two write recorders and the read responder
`timescale 1ns/10ps
`include "mmio_test_config.svh"

module mmio_test_afu
    import mmio_test_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  mmio64_req_t  mmio64_req,
    output logic         mmio64_waitrequest,
    output mmio64_rsp_t  mmio64_rsp,
    input  mmio512_req_t mmio512_req,
    output logic         mmio512_waitrequest
);

    // accept qualifiers, request seen while the port is ready
    logic rd64_accept;
    logic wr64_accept;
    logic wr512_accept;

    assign rd64_accept  = mmio64_req.read && !mmio64_waitrequest;
    assign wr64_accept  = mmio64_req.write && !mmio64_waitrequest;
    assign wr512_accept = mmio512_req.write && !mmio512_waitrequest;

    waitrequest_gen u_wait (
        .clk     (clk),
        .reset_n (reset_n),
        .wait64  (mmio64_waitrequest),
        .wait512 (mmio512_waitrequest)
    );

    // ========================================================================
    // write records
    // ========================================================================

    logic [63:0]                rec64_data;
    logic [`MMIO64_ADDR_W-1:0]  rec64_addr;
    logic [7:0]                 rec64_mask;
    logic [2:0]                 rec64_byte_idx;

    logic [511:0]               rec512_bits;
    wide_data_u                 rec512_data;
    logic [`MMIO512_ADDR_W-1:0] rec512_addr;
    logic [63:0]                rec512_mask;
    logic [5:0]                 rec512_byte_idx;

    mmio_write_capture #(
        .BYTES  (8),
        .ADDR_W (`MMIO64_ADDR_W)
    ) u_cap64 (
        .clk          (clk),
        .reset_n      (reset_n),
        .write        (wr64_accept),
        .address      (mmio64_req.address),
        .byteenable   (mmio64_req.byteenable),
        .writedata    (mmio64_req.writedata),
        .rec_data     (rec64_data),
        .rec_addr     (rec64_addr),
        .rec_mask     (rec64_mask),
        .rec_byte_idx (rec64_byte_idx)
    );

    mmio_write_capture #(
        .BYTES  (64),
        .ADDR_W (`MMIO512_ADDR_W)
    ) u_cap512 (
        .clk          (clk),
        .reset_n      (reset_n),
        .write        (wr512_accept),
        .address      (mmio512_req.address),
        .byteenable   (mmio512_req.byteenable),
        .writedata    (mmio512_req.writedata),
        .rec_data     (rec512_bits),
        .rec_addr     (rec512_addr),
        .rec_mask     (rec512_mask),
        .rec_byte_idx (rec512_byte_idx)
    );

    // responder reads the wide record as eight words
    assign rec512_data.bits = rec512_bits;

    // ========================================================================
    // reads
    // ========================================================================

    mmio_read_responder u_rd (
        .clk             (clk),
        .reset_n         (reset_n),
        .read_accept     (rd64_accept),
        .address         (mmio64_req.address),
        .byteenable      (mmio64_req.byteenable),
        .user            (mmio64_req.user),
        .rec64_data      (rec64_data),
        .rec64_addr      (rec64_addr),
        .rec64_mask      (rec64_mask),
        .rec64_byte_idx  (rec64_byte_idx),
        .rec512_data     (rec512_data),
        .rec512_addr     (rec512_addr),
        .rec512_mask     (rec512_mask),
        .rec512_byte_idx (rec512_byte_idx),
        .rsp             (mmio64_rsp)
    );

endmodule

//--- rtl/mmio_test_config.svh
// build-time constants for the mmio test target
// accelerator id, clock rate, address and user-tag widths
`ifndef MMIO_TEST_CONFIG_SVH
`define MMIO_TEST_CONFIG_SVH

// ============================================================================
// accelerator identity
// ============================================================================

// low and high 64-bit halves of the 128-bit accelerator id
`define MMIO_AFU_ID_L 64'h9a3c_51e7_02f4_6b8d
`define MMIO_AFU_ID_H 64'h4e17_c2a0_7d95_3f61

// host-channel clock in MHz, reported in the status register
`define MMIO_PCLK_MHZ 16'd250

// ============================================================================
// bus geometry
// ============================================================================

// word-address widths, 64-bit and 512-bit ports
`define MMIO64_ADDR_W 16
`define MMIO512_ADDR_W 10

// width of the tag returned with each read response
`define MMIO_USER_W 8

`endif

//--- rtl/mmio_test_pkg.sv
// request and response structs for both mmio ports
// wide-data union, register index type and lowest-byte search
`include "mmio_test_config.svh"

package mmio_test_pkg;

    // 64-bit read/write port, driven by the host
    typedef struct packed {
        logic                      read;
        logic                      write;
        logic [`MMIO64_ADDR_W-1:0] address;
        logic [7:0]                byteenable;
        logic [63:0]               writedata;
        logic [`MMIO_USER_W-1:0]   user;
    } mmio64_req_t;

    // read response, no back-pressure
    typedef struct packed {
        logic                    readdatavalid;
        logic [63:0]             readdata;
        logic [`MMIO_USER_W-1:0] readresponseuser;
    } mmio64_rsp_t;

    // 512-bit port is write-only, so no read strobe
    typedef struct packed {
        logic                       write;
        logic [`MMIO512_ADDR_W-1:0] address;
        logic [63:0]                byteenable;
        logic [511:0]               writedata;
    } mmio512_req_t;

    // one wide word, either flat or as eight 64-bit registers
    typedef union packed {
        logic [511:0]     bits;
        logic [7:0][63:0] words;
    } wide_data_u;

    // register index into the 64-bit csr space
    typedef logic [11:0] csr_idx_t;

    // position of the lowest set byteenable bit
    // an empty mask gives 0, callers never pass one
    function automatic logic [5:0] lowest_byte_idx(input logic [63:0] mask);
        logic [5:0] idx;
        idx = '0;
        // scan downwards so the lowest hit wins
        for (int i = 63; i >= 0; i--)
        begin
            if (mask[i])
                idx = 6'(i);
        end
        return idx;
    endfunction

endpackage

//--- rtl/mmio_write_capture.sv
// last-write recorder for one mmio port, any power-of-two byte width
// keeps merged data, word address, mask and lowest enabled byte
`timescale 1ns/10ps

module mmio_write_capture
    import mmio_test_pkg::*;
#(
    parameter int BYTES  = 8,
    parameter int ADDR_W = 16
)
(
    input  logic                     clk,
    input  logic                     reset_n,
    // already qualified by waitrequest at the top level
    input  logic                     write,
    input  logic [ADDR_W-1:0]        address,
    input  logic [BYTES-1:0]         byteenable,
    input  logic [BYTES*8-1:0]       writedata,
    output logic [BYTES*8-1:0]       rec_data,
    output logic [ADDR_W-1:0]        rec_addr,
    output logic [BYTES-1:0]         rec_mask,
    output logic [$clog2(BYTES)-1:0] rec_byte_idx
);

    localparam int IDX_W = $clog2(BYTES);

    // ========================================================================
    // byte merge
    // ========================================================================

    // unenabled lanes keep what the previous writes left
    logic [BYTES*8-1:0] merged;
    logic [IDX_W-1:0]   low_idx;

    always_comb
    begin
        merged = rec_data;
        for (int i = 0; i < BYTES; i++)
        begin
            if (byteenable[i])
                merged[i*8 +: 8] = writedata[i*8 +: 8];
        end
    end

    // byte offset of the access inside the bus word
    assign low_idx = IDX_W'(lowest_byte_idx(64'(byteenable)));

    // ========================================================================
    // record registers
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rec_data     <= '0;
            rec_addr     <= '0;
            rec_mask     <= '0;
            rec_byte_idx <= '0;
        end
        else if (write)
        begin
            rec_data     <= merged;
            rec_addr     <= address;
            rec_mask     <= byteenable;
            rec_byte_idx <= low_idx;
        end
    end

    // an accepted write always carries at least one byte
    a_write_has_bytes: assert property (
        @(posedge clk) disable iff (!reset_n)
        write |-> (|byteenable)
    );

endmodule

//--- rtl/waitrequest_gen.sv
// rotating waitrequest pattern for both slave ports
`timescale 1ns/10ps

module waitrequest_gen
(
    input  logic clk,
    input  logic reset_n,
    output logic wait64,
    output logic wait512
);

    // single zero walks upward, one ready slot every 16 cycles
    logic [15:0] wait_vec;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            wait_vec <= {{15{1'b1}}, 1'b0};
        else
            wait_vec <= {wait_vec[14:0], wait_vec[15]};
    end

    // narrow port ready right after reset, wide port 8 cycles later
    assign wait64  = wait_vec[0];
    assign wait512 = wait_vec[8];

    // the pattern must never lose or gain a ready slot
    a_one_ready_slot: assert property (
        @(posedge clk) disable iff (!reset_n)
        $countones(~wait_vec) == 1
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the mmio test target with Verilator and run the testbench

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f verilog.f --top-module mmio_test_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vmmio_test_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

echo "simulation completed"
exit 0

//--- verification/mmio_test_tb.sv
// testbench for the mmio test target
// bus tasks, reference model of both write records, response assertions
`timescale 1ns/10ps
`include "mmio_test_config.svh"

module mmio_test_tb
    import mmio_test_pkg::*;
();

    localparam int USER_W = `MMIO_USER_W;
    localparam int A64_W  = `MMIO64_ADDR_W;
    localparam int A512_W = `MMIO512_ADDR_W;

    logic         clk;
    logic         reset_n;
    mmio64_req_t  req64;
    mmio512_req_t req512;
    logic         wait64;
    logic         wait512;
    mmio64_rsp_t  rsp64;
    int           seed;

    // expected responses, pushed at accept and popped after each response
    logic [63:0]       exp_data [0:255];
    logic [USER_W-1:0] exp_user [0:255];
    string             exp_name [0:255];
    logic [7:0]        wr_ptr;
    logic [7:0]        rd_ptr;

    // position inside the 16-cycle ready rotation
    logic [3:0]        slot;

    // reference copies of the two write records
    logic [63:0]       m64_data;
    logic [A64_W-1:0]  m64_addr;
    logic [7:0]        m64_mask;
    logic [2:0]        m64_idx;
    logic [511:0]      m512_data;
    logic [A512_W-1:0] m512_addr;
    logic [63:0]       m512_mask;
    logic [5:0]        m512_idx;

    mmio_test_afu dut (
        .clk                 (clk),
        .reset_n             (reset_n),
        .mmio64_req          (req64),
        .mmio64_waitrequest  (wait64),
        .mmio64_rsp          (rsp64),
        .mmio512_req         (req512),
        .mmio512_waitrequest (wait512)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================================================
    // reference model
    // ========================================================================

    // first enabled lane, counting up from byte 0
    function automatic int first_set_byte(input logic [63:0] mask);
        int n;
        n = 0;
        while (n < 63 && !mask[n])
            n++;
        return n;
    endfunction

    // register map as seen by a read of addr with byteenable be
    function automatic logic [63:0] expected_read(input logic [A64_W-1:0] addr,
                                                  input logic [7:0] be);
        logic [31:0] byte_addr;
        byte_addr = 32'(addr) * 32'd8 + 32'(first_set_byte(64'(be)));
        case (addr)
            16'h0000: return (64'h1 << 60) | (64'h1 << 40);
            16'h0001: return `MMIO_AFU_ID_L;
            16'h0002: return `MMIO_AFU_ID_H;
            16'h0007: return {byte_addr, byte_addr};
            16'h0010: return (64'(`MMIO_PCLK_MHZ) << 16) | 64'h10;
            16'h0020: return m64_data;
            16'h0030: return 64'(m64_addr) * 64'd8 + 64'(m64_idx);
            16'h0031: return 64'(m64_mask);
            16'h0050: return 64'(m512_addr) * 64'd64 + 64'(m512_idx);
            16'h0051: return m512_mask;
            default:
            begin
                // eight wide-data words, anything else reads as zero
                if (addr >= 16'h0040 && addr <= 16'h0047)
                    return m512_data[addr[2:0]*64 +: 64];
                return 64'h0;
            end
        endcase
    endfunction

    function automatic logic [63:0] rand64();
        return {32'($random(seed)), 32'($random(seed))};
    endfunction

    // ========================================================================
    // bus tasks
    // ========================================================================

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // request already on the bus, step until the accepting edge has passed
    task automatic wait_ready(input bit wide, input string what);
        int cycles;
        cycles = 0;
        while ((wide ? wait512 : wait64) == 1'b1)
        begin
            next_cycle();
            cycles++;
            if (cycles > 40)
                stop_with_failure($sformatf("timeout: %s was never accepted", what));
        end
        next_cycle();
    endtask

    task automatic write64(input logic [A64_W-1:0] addr, input logic [7:0] be,
                           input logic [63:0] data);
        int i;
        req64.write      = 1'b1;
        req64.address    = addr;
        req64.byteenable = be;
        req64.writedata  = data;
        wait_ready(1'b0, "64-bit write");
        req64.write = 1'b0;
        // merge only the enabled lanes into the model
        for (i = 0; i < 8; i++)
        begin
            if (be[i])
                m64_data[i*8 +: 8] = data[i*8 +: 8];
        end
        m64_addr = addr;
        m64_mask = be;
        m64_idx  = 3'(first_set_byte(64'(be)));
    endtask

    task automatic write512(input logic [A512_W-1:0] addr, input logic [63:0] be,
                            input logic [511:0] data);
        int i;
        req512.write      = 1'b1;
        req512.address    = addr;
        req512.byteenable = be;
        req512.writedata  = data;
        wait_ready(1'b1, "512-bit write");
        req512.write = 1'b0;
        for (i = 0; i < 64; i++)
        begin
            if (be[i])
                m512_data[i*8 +: 8] = data[i*8 +: 8];
        end
        m512_addr = addr;
        m512_mask = be;
        m512_idx  = 6'(first_set_byte(be));
    endtask

    // expected value is taken from the model at the accepting edge
    task automatic read64(input logic [A64_W-1:0] addr, input logic [7:0] be,
                          input logic [USER_W-1:0] tag, input string name);
        req64.read       = 1'b1;
        req64.address    = addr;
        req64.byteenable = be;
        req64.user       = tag;
        wait_ready(1'b0, "64-bit read");
        req64.read = 1'b0;
        exp_data[wr_ptr] = expected_read(addr, be);
        exp_user[wr_ptr] = tag;
        exp_name[wr_ptr] = name;
        wr_ptr = wr_ptr + 8'd1;
    endtask

    // ========================================================================
    // response checks
    // ========================================================================

    // head moves right after the edge that checked the response
    always @(posedge clk)
    begin
        if (!reset_n)
            rd_ptr <= 8'd0;
        else if (rsp64.readdatavalid)
            rd_ptr <= rd_ptr + 8'd1;
    end

    // 0 on the first cycle after reset, wraps every 16 cycles
    always @(posedge clk)
    begin
        if (!reset_n)
            slot <= 4'd0;
        else
            slot <= slot + 4'd1;
    end

    a_rsp_pending: assert property (@(posedge clk) disable iff (!reset_n)
        rsp64.readdatavalid |-> (rd_ptr != wr_ptr))
        else stop_with_failure("read response arrived with no read outstanding");

    a_rsp_data: assert property (@(posedge clk) disable iff (!reset_n)
        rsp64.readdatavalid |-> (rsp64.readdata == exp_data[rd_ptr]))
        else stop_with_failure($sformatf("ERROR %s: readdata expected %h actual %h",
            exp_name[$sampled(rd_ptr)], exp_data[$sampled(rd_ptr)],
            $sampled(rsp64.readdata)));

    a_rsp_user: assert property (@(posedge clk) disable iff (!reset_n)
        rsp64.readdatavalid |-> (rsp64.readresponseuser == exp_user[rd_ptr]))
        else stop_with_failure($sformatf("ERROR %s: user tag expected %h actual %h",
            exp_name[$sampled(rd_ptr)], exp_user[$sampled(rd_ptr)],
            $sampled(rsp64.readresponseuser)));

    // exactly two cycles from accept to response, both directions
    a_latency_fwd: assert property (@(posedge clk) disable iff (!reset_n)
        (req64.read && !wait64) |-> ##2 rsp64.readdatavalid)
        else stop_with_failure("read response missing two cycles after the accept");

    a_latency_back: assert property (@(posedge clk) disable iff (!reset_n)
        rsp64.readdatavalid |-> $past(req64.read && !wait64, 2))
        else stop_with_failure("read response without a read accepted two cycles before");

    // one ready slot in 16 per port, wide port 8 cycles behind the narrow one
    a_wait_pattern: assert property (@(posedge clk) disable iff (!reset_n)
        (wait64 == (slot != 4'd0)) && (wait512 == (slot != 4'd8)))
        else stop_with_failure($sformatf("ERROR waitrequest: expected %b actual %b",
            {$sampled(slot) != 4'd8, $sampled(slot) != 4'd0},
            {$sampled(wait512), $sampled(wait64)}));

    // ========================================================================
    // stimulus
    // ========================================================================

    initial
    begin : stimulus
        int                i;
        int                cycles;
        logic [7:0]        be;
        logic [63:0]       wide_be;
        logic [511:0]      wide_data;

        seed      = 32'h5bb0;
        reset_n   = 1'b0;
        req64     = '0;
        req512    = '0;
        wr_ptr    = 8'd0;
        m64_data  = '0;
        m64_addr  = '0;
        m64_mask  = '0;
        m64_idx   = '0;
        m512_data = '0;
        m512_addr = '0;
        m512_mask = '0;
        m512_idx  = '0;
        repeat (3) @(posedge clk);
        #1 reset_n = 1'b1;

        // fixed registers
        read64(16'h0000, 8'hff, USER_W'($random(seed)), "csr_header");
        read64(16'h0001, 8'hff, USER_W'($random(seed)), "afu_id_low");
        read64(16'h0002, 8'hff, USER_W'($random(seed)), "afu_id_high");
        read64(16'h0010, 8'hff, USER_W'($random(seed)), "status");

        // full-mask narrow writes
        for (i = 0; i < 3; i++)
        begin
            write64(A64_W'($random(seed)), 8'hff, rand64());
            read64(16'h0020, 8'hff, USER_W'($random(seed)), "wr64_full_data");
            read64(16'h0030, 8'hff, USER_W'($random(seed)), "wr64_full_addr");
            read64(16'h0031, 8'hff, USER_W'($random(seed)), "wr64_full_mask");
        end

        // partial masks, never empty and never full
        for (i = 0; i < 4; i++)
        begin
            be = 8'($random(seed)) & 8'h7e;
            if (be == 8'h00)
                be = 8'h10;
            write64(A64_W'($random(seed)), be, rand64());
            read64(16'h0020, 8'hff, USER_W'($random(seed)), "wr64_part_data");
            read64(16'h0030, 8'hff, USER_W'($random(seed)), "wr64_part_addr");
            read64(16'h0031, 8'hff, USER_W'($random(seed)), "wr64_part_mask");
        end

        // two wide writes merge into one record
        for (i = 0; i < 2; i++)
        begin
            wide_be = rand64();
            if (wide_be == 64'h0)
                wide_be = 64'h8000_0000_0000_0001;
            wide_data = {rand64(), rand64(), rand64(), rand64(),
                         rand64(), rand64(), rand64(), rand64()};
            write512(A512_W'($random(seed)), wide_be, wide_data);
        end
        for (i = 0; i < 8; i++)
            read64(16'h0040 + 16'(i), 8'hff, USER_W'($random(seed)), "wr512_word");
        read64(16'h0050, 8'hff, USER_W'($random(seed)), "wr512_addr");
        read64(16'h0051, 8'hff, USER_W'($random(seed)), "wr512_mask");

        // byte address of the request itself
        read64(16'h0007, 8'h10, USER_W'($random(seed)), "byte_addr");
        read64(16'h0007, 8'hc0, USER_W'($random(seed)), "byte_addr");
        read64(16'h0007, 8'h06, USER_W'($random(seed)), "byte_addr");

        // holes in the map
        read64(16'h0003, 8'hff, USER_W'($random(seed)), "unmapped");
        read64(16'h0011, 8'hff, USER_W'($random(seed)), "unmapped");
        read64(16'h0048, 8'hff, USER_W'($random(seed)), "unmapped");
        read64(16'h0052, 8'hff, USER_W'($random(seed)), "unmapped");
        read64(16'h0100, 8'hff, USER_W'($random(seed)), "unmapped");
        read64(16'h0fff, 8'hff, USER_W'($random(seed)), "unmapped");

        // back-to-back reads, distinct tags must come back in order
        for (i = 0; i < 6; i++)
            read64(16'h0040 + 16'(i), 8'hff, USER_W'(8'ha0 + i), "tag_order");

        // let the last responses drain
        cycles = 0;
        while (rd_ptr != wr_ptr)
        begin
            next_cycle();
            cycles++;
            if (cycles > 40)
                stop_with_failure("timeout: read responses still outstanding at the end");
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/mmio_test_pkg.sv
rtl/waitrequest_gen.sv
rtl/mmio_write_capture.sv
rtl/mmio_read_responder.sv
rtl/mmio_test_afu.sv
verification/mmio_test_tb.sv
